// ==== files.f ====
source/ifu_pkg.sv
source/ifu_minidec.sv
source/ifu_bpu.sv
source/ifu_ifetch.sv
source/ifu_itcm.sv
source/ifu_top.sv
dv/ifu_asserts.sv
dv/ifu_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ifu_tb -f files.f -o ifu_sim \
   || { echo "build failed"; exit 1; }
./obj_dir/ifu_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== dv/ifu_tb.sv ====
`timescale 1ns/1ps

module ifu_tb;
   import ifu_pkg::*;

   logic                  clk;
   logic                  rst_n;
   logic [PC_SIZE-1:0]    pc_rtvec;
   logic                  load_en;
   logic [ITCM_AW-1:0]    load_addr;
   logic [INSTR_SIZE-1:0] load_data;
   if_ex_t                ex;
   logic                  ex_valid;
   logic                  ex_ready;
   logic                  flush_req;
   flush_t                flush;
   logic [XLEN-1:0]       rf_x1;
   logic                  x1_busy;
   logic [PC_SIZE-1:0]    cur_pc;

   // program image and pc expected at the next handover
   logic [INSTR_SIZE-1:0] prog [0:(1<<ITCM_AW)-1];
   logic [PC_SIZE-1:0]    exp_pc;
   logic                  rand_ready;
   // 0 running, 1 passed, 2 failure reported
   logic [1:0]            run_state;
   int                    n;

   ifu_top DUT (.*);

   always #4 clk = ~clk;

   // run stopped before the last test finished
   final begin
      if (run_state == 2'd0) begin
         $display("tests failed");
      end
   end

   task automatic stop_on_error();
      run_state = 2'd2;
      $display("tests failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input logic [31:0] expv, input logic [31:0] actv);
      $display("FAIL %s %s expected %h actual %h", name, what, expv, actv);
      stop_on_error();
   endtask

   // addi whose immediate and registers follow the word address
   function automatic logic [31:0] fill_word(input logic [5:0] a);
      return {6'd0, a, a[4:0], 3'b000, a[4:0], 7'b0010011};
   endfunction

   // static rule, result is {taken, next pc}
   function automatic logic [32:0] predict(input logic [31:0] ir, input logic [31:0] pc);
      logic [31:0] imm_j;
      logic [31:0] imm_b;
      logic [31:0] imm_i;
      logic [32:0] res;
      imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      imm_i = {{20{ir[31]}}, ir[31:20]};
      res   = {1'b0, pc + 32'd4};
      case (ir[6:0])
         7'b1101111: res = {1'b1, pc + imm_j};
         7'b1100011: begin
            if (imm_b[31]) res = {1'b1, pc + imm_b};
         end
         7'b1100111: begin
            if (ir[19:15] == 5'd0) res = {1'b1, imm_i};
            else if (ir[19:15] == 5'd1) res = {1'b1, rf_x1 + imm_i};
         end
         default: ;
      endcase
      res[1:0] = 2'b00;
      return res;
   endfunction

   task automatic reset_and_load(input logic [31:0] rtvec);
      int i;
      @(negedge clk);
      rst_n    = 1'b0;
      pc_rtvec = rtvec;
      ex_ready = 1'b0;
      for (i = 0; i < (1 << ITCM_AW); i++) begin
         load_en   = 1'b1;
         load_addr = ITCM_AW'(i);
         load_data = prog[ITCM_AW'(i)];
         @(negedge clk);
      end
      load_en = 1'b0;
      repeat (5) @(negedge clk);
      rst_n  = 1'b1;
      exp_pc = {rtvec[31:2], 2'b00};
   endtask

   // wait for one ex handshake and compare it with the model
   task automatic accept_one(input string name);
      int          cyc;
      logic        got;
      logic        use_rs1;
      logic        use_rs2;
      logic [31:0] exp_ir;
      logic [32:0] prd;
      got = 1'b0;
      for (cyc = 0; cyc < 200 && !got; cyc++) begin
         @(negedge clk);
         ex_ready = rand_ready ? (($urandom % 3) != 0) : 1'b1;
         got      = ex_valid & ex_ready;
      end
      if (!got) begin
         $display("%s: instruction never became valid", name);
         stop_on_error();
      end else begin
         exp_ir  = prog[exp_pc[ITCM_AW+1:2]];
         prd     = predict(exp_ir, exp_pc);
         use_rs1 = exp_ir[6:0] inside {7'b1100111, 7'b1100011, 7'b0000011,
                                       7'b0010011, 7'b0100011, 7'b0110011};
         use_rs2 = exp_ir[6:0] inside {7'b1100011, 7'b0100011, 7'b0110011};
         assert (ex.pc == exp_pc) else report_mismatch(name, "pc", exp_pc, ex.pc);
         assert (ex.ir == exp_ir) else report_mismatch(name, "ir", exp_ir, ex.ir);
         assert (ex.prdt_taken == prd[32])
            else report_mismatch(name, "prdt_taken", 32'(prd[32]), 32'(ex.prdt_taken));
         assert (!use_rs1 || ex.rs1idx == exp_ir[19:15])
            else report_mismatch(name, "rs1idx", 32'(exp_ir[19:15]), 32'(ex.rs1idx));
         assert (!use_rs2 || ex.rs2idx == exp_ir[24:20])
            else report_mismatch(name, "rs2idx", 32'(exp_ir[24:20]), 32'(ex.rs2idx));
         // fetch already points at the predicted successor
         assert (cur_pc == prd[31:0])
            else report_mismatch(name, "cur_pc", prd[31:0], cur_pc);
         exp_pc = prd[31:0];
      end
   endtask

   // one cycle strobe, execute held off so nothing old gets through
   task automatic flush_to(input logic [31:0] op1, input logic [31:0] op2);
      @(negedge clk);
      ex_ready      = 1'b0;
      flush_req     = 1'b1;
      flush.add_op1 = op1;
      flush.add_op2 = op2;
      exp_pc        = (op1 + op2) & ~32'd3;
      @(negedge clk);
      flush_req     = 1'b0;
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      pc_rtvec   = '0;
      load_en    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      ex_ready   = 1'b0;
      flush_req  = 1'b0;
      flush      = '0;
      rf_x1      = '0;
      x1_busy    = 1'b0;
      rand_ready = 1'b0;
      run_state  = 2'd0;
      void'($urandom(28916));

      // straight line code, crosses the top of the memory
      for (n = 0; n < (1 << ITCM_AW); n++) begin
         prog[ITCM_AW'(n)] = fill_word(6'(n));
      end
      reset_and_load(32'h0000_0080);
      repeat (40) accept_one("sequential");

      // jal +16, forward beq, backward bne -12
      prog[1] = 32'h0100_006F;
      prog[5] = 32'h0031_0463;
      prog[6] = 32'hFE52_1AE3;
      reset_and_load(32'h0000_0000);
      repeat (12) accept_one("branch");

      // jalr via x0, via x1 with a pending write, then via x5
      prog[0]  = 32'h0400_0067;
      prog[16] = 32'h0040_8067;
      prog[10] = 32'h0002_8067;
      rf_x1    = 32'h0000_001C;
      x1_busy  = 1'b1;
      reset_and_load(32'h0000_0000);
      accept_one("jalr");
      for (n = 0; n < 20; n++) begin
         @(negedge clk);
         assert (!ex_valid) else begin
            $display("jalr: instruction became valid while x1 was busy");
            stop_on_error();
         end
      end
      x1_busy = 1'b0;
      repeat (6) accept_one("jalr");

      for (n = 0; n < (1 << ITCM_AW); n++) begin
         prog[ITCM_AW'(n)] = fill_word(6'(n));
      end
      rand_ready = 1'b1;
      reset_and_load(32'h0000_0080);
      repeat (40) accept_one("backpressure");

      reset_and_load(32'h0000_0000);
      for (n = 0; n < 3; n++) begin
         repeat (1 + $urandom % 6) accept_one("flush");
         flush_to($urandom, $urandom);
         repeat (8) accept_one("flush");
      end

      run_state = 2'd1;
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== dv/ifu_asserts.sv ====
`timescale 1ns/1ps

module ifu_asserts (
   input logic            clk,
   input logic            rst_n,
   input logic            ex_valid,
   input logic            ex_ready,
   input logic            flush_req,
   input ifu_pkg::if_ex_t ex
);

   // no handover while reset is applied
   reset_idle: assert property (@(posedge clk) !rst_n |-> !ex_valid)
      else $error("ex_valid high during reset");

   // payload held until execute takes it
   ex_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid && !ex_ready && !flush_req |=> ex_valid && $stable(ex))
      else $error("ex changed or dropped while waiting for ex_ready");

   pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      ex_valid |-> ex.pc[1:0] == 2'b00)
      else $error("ex.pc is not word aligned");

   // flush empties the instruction register
   flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
      flush_req |=> !ex_valid)
      else $error("ex_valid high in the cycle after a flush");

endmodule

bind ifu_top ifu_asserts u_asserts (
   .clk       (clk),
   .rst_n     (rst_n),
   .ex_valid  (ex_valid),
   .ex_ready  (ex_ready),
   .flush_req (flush_req),
   .ex        (ex)
);

// ==== source/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [ifu_pkg::PC_SIZE-1:0]    pc_rtvec,
   input  logic                           load_en,
   input  logic [ifu_pkg::ITCM_AW-1:0]    load_addr,
   input  logic [ifu_pkg::INSTR_SIZE-1:0] load_data,
   output ifu_pkg::if_ex_t                ex,
   output logic                           ex_valid,
   input  logic                           ex_ready,
   input  logic                           flush_req,
   input  ifu_pkg::flush_t                flush,
   input  logic [ifu_pkg::XLEN-1:0]       rf_x1,
   input  logic                           x1_busy,
   output logic [ifu_pkg::PC_SIZE-1:0]    cur_pc
);
   import ifu_pkg::*;

   // fetch to itcm channels
   logic                  req_valid;
   logic                  req_ready;
   logic [PC_SIZE-1:0]    req_pc;
   logic                  rsp_valid;
   logic                  rsp_ready;
   logic [INSTR_SIZE-1:0] rsp_instr;

   ifu_ifetch u_ifetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .pc_rtvec  (pc_rtvec),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_pc    (req_pc),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_instr (rsp_instr),
      .ex        (ex),
      .ex_valid  (ex_valid),
      .ex_ready  (ex_ready),
      .flush_req (flush_req),
      .flush     (flush),
      .rf_x1     (rf_x1),
      .x1_busy   (x1_busy),
      .cur_pc    (cur_pc)
   );

   ifu_itcm u_itcm (
      .clk       (clk),
      .rst_n     (rst_n),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_pc    (req_pc),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_instr (rsp_instr)
   );

endmodule

// ==== source/ifu_itcm.sv ====
`timescale 1ns/1ps

module ifu_itcm (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           load_en,
   input  logic [ifu_pkg::ITCM_AW-1:0]    load_addr,
   input  logic [ifu_pkg::INSTR_SIZE-1:0] load_data,
   input  logic                           req_valid,
   output logic                           req_ready,
   input  logic [ifu_pkg::PC_SIZE-1:0]    req_pc,
   output logic                           rsp_valid,
   input  logic                           rsp_ready,
   output logic [ifu_pkg::INSTR_SIZE-1:0] rsp_instr
);
   import ifu_pkg::*;

   logic [INSTR_SIZE-1:0] mem [0:(1<<ITCM_AW)-1];
   logic [ITCM_AW-1:0]    req_addr;
   logic                  req_hsk;

   // word address, upper pc bits wrap
   assign req_addr  = req_pc[ITCM_AW+1:2];

   // free once the held response leaves, even in the same cycle
   assign req_ready = ~rsp_valid | rsp_ready;
   assign req_hsk   = req_valid & req_ready;

   // program load port
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // output register only changes on a new request
   always_ff @(posedge clk) begin
      if (req_hsk) begin
         rsp_instr <= mem[req_addr];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (req_hsk) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

endmodule

// ==== source/ifu_ifetch.sv ====
`timescale 1ns/1ps

module ifu_ifetch (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [ifu_pkg::PC_SIZE-1:0]    pc_rtvec,
   output logic                           req_valid,
   input  logic                           req_ready,
   output logic [ifu_pkg::PC_SIZE-1:0]    req_pc,
   input  logic                           rsp_valid,
   output logic                           rsp_ready,
   input  logic [ifu_pkg::INSTR_SIZE-1:0] rsp_instr,
   output ifu_pkg::if_ex_t                ex,
   output logic                           ex_valid,
   input  logic                           ex_ready,
   input  logic                           flush_req,
   input  ifu_pkg::flush_t                flush,
   input  logic [ifu_pkg::XLEN-1:0]       rf_x1,
   input  logic                           x1_busy,
   output logic [ifu_pkg::PC_SIZE-1:0]    cur_pc
);
   import ifu_pkg::*;

   logic [PC_SIZE-1:0] pc_r;
   logic               reset_req_r;
   logic               inflight_r;
   logic               discard_r;
   logic               ir_valid_r;
   if_ex_t             ir_r;

   minidec_t           dec;
   logic               prdt_taken;
   logic               bpu_wait;
   logic [PC_SIZE-1:0] prdt_add_op1;
   logic [PC_SIZE-1:0] prdt_add_op2;
   logic [PC_SIZE-1:0] add_op1;
   logic [PC_SIZE-1:0] add_op2;
   logic [PC_SIZE-1:0] pc_sum;
   logic [PC_SIZE-1:0] pc_nxt;

   logic rsp_live;
   logic capture;
   logic ex_hsk;
   logic req_hsk;
   logic rsp_hsk;

   ifu_minidec u_minidec (
      .instr (rsp_instr),
      .dec   (dec)
   );

   ifu_bpu u_bpu (
      .pc           (pc_r),
      .dec          (dec),
      .dec_valid    (rsp_live),
      .rf_x1        (rf_x1),
      .x1_busy      (x1_busy),
      .prdt_taken   (prdt_taken),
      .prdt_add_op1 (prdt_add_op1),
      .prdt_add_op2 (prdt_add_op2),
      .bpu_wait     (bpu_wait)
   );

   // response of the current path only
   assign rsp_live  = rsp_valid & ~discard_r;
   assign ex_hsk    = ir_valid_r & ex_ready;
   assign capture   = rsp_live & ~bpu_wait & ~flush_req & (~ir_valid_r | ex_ready);

   // flush and stale responses are accepted and dropped
   assign rsp_ready = capture | flush_req | discard_r;
   assign rsp_hsk   = rsp_valid & rsp_ready;

   assign req_valid = reset_req_r | capture | flush_req;
   assign req_hsk   = req_valid & req_ready;

   // shared pc adder, reset > flush > predicted jump > sequential
   always_comb begin
      if (reset_req_r) begin
         add_op1 = pc_rtvec;
         add_op2 = '0;
      end else if (flush_req) begin
         add_op1 = flush.add_op1;
         add_op2 = flush.add_op2;
      end else if (prdt_taken) begin
         add_op1 = prdt_add_op1;
         add_op2 = prdt_add_op2;
      end else begin
         add_op1 = pc_r;
         add_op2 = PC_SIZE'(4);
      end
   end

   assign pc_sum = add_op1 + add_op2;
   assign pc_nxt = {pc_sum[PC_SIZE-1:2], 2'b00};
   assign req_pc = pc_nxt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_r        <= {pc_rtvec[PC_SIZE-1:2], 2'b00};
         reset_req_r <= 1'b1;
         inflight_r  <= 1'b0;
         discard_r   <= 1'b0;
         ir_valid_r  <= 1'b0;
      end else begin
         // pc of the outstanding request
         if (req_valid) begin
            pc_r <= pc_nxt;
         end
         if (req_hsk) begin
            reset_req_r <= 1'b0;
         end
         inflight_r <= req_hsk | (inflight_r & ~rsp_hsk);
         // old path request still out, its response must be dropped
         discard_r  <= (discard_r | (flush_req & inflight_r)) & ~rsp_valid;
         if (flush_req) begin
            ir_valid_r <= 1'b0;
         end else if (capture) begin
            ir_valid_r <= 1'b1;
         end else if (ex_hsk) begin
            ir_valid_r <= 1'b0;
         end
      end
   end

   // instruction register payload
   always_ff @(posedge clk) begin
      if (capture) begin
         ir_r.ir         <= rsp_instr;
         ir_r.pc         <= pc_r;
         ir_r.rs1idx     <= dec.rs1en ? dec.rs1idx : '0;
         ir_r.rs2idx     <= dec.rs2en ? dec.rs2idx : '0;
         ir_r.prdt_taken <= prdt_taken;
      end
   end

   assign ex       = ir_r;
   assign ex_valid = ir_valid_r;
   assign cur_pc   = pc_r;

endmodule

// ==== source/ifu_bpu.sv ====
`timescale 1ns/1ps

module ifu_bpu (
   input  logic [ifu_pkg::PC_SIZE-1:0] pc,
   input  ifu_pkg::minidec_t           dec,
   input  logic                        dec_valid,
   input  logic [ifu_pkg::XLEN-1:0]    rf_x1,
   input  logic                        x1_busy,
   output logic                        prdt_taken,
   output logic [ifu_pkg::PC_SIZE-1:0] prdt_add_op1,
   output logic [ifu_pkg::PC_SIZE-1:0] prdt_add_op2,
   output logic                        bpu_wait
);
   import ifu_pkg::*;

   logic jalr_x0;
   logic jalr_x1;
   logic taken;

   // jalr base register classes that can be predicted
   assign jalr_x0 = (dec.kind == BJP_JALR) && (dec.rs1idx == RFIDX_WIDTH'(0));
   assign jalr_x1 = (dec.kind == BJP_JALR) && (dec.rs1idx == RFIDX_WIDTH'(1));

   always_comb begin
      // sequential by default
      taken        = 1'b0;
      prdt_add_op1 = pc;
      prdt_add_op2 = PC_SIZE'(4);
      case (dec.kind)
         BJP_JAL: begin
            taken        = 1'b1;
            prdt_add_op2 = PC_SIZE'(dec.bjp_imm);
         end
         BJP_BXX: begin
            // backward taken, forward not taken
            if (dec.bjp_imm[XLEN-1]) begin
               taken        = 1'b1;
               prdt_add_op2 = PC_SIZE'(dec.bjp_imm);
            end
         end
         BJP_JALR: begin
            if (jalr_x0) begin
               taken        = 1'b1;
               prdt_add_op1 = '0;
               prdt_add_op2 = PC_SIZE'(dec.bjp_imm);
            end else if (jalr_x1) begin
               taken        = 1'b1;
               prdt_add_op1 = PC_SIZE'(rf_x1);
               prdt_add_op2 = PC_SIZE'(dec.bjp_imm);
            end
            // other base registers fall through as not taken,
            // execute redirects with a flush
         end
         default: begin
            taken        = 1'b0;
         end
      endcase
   end

   assign prdt_taken = dec_valid & taken;

   // x1 value not yet final, hold the response
   assign bpu_wait   = dec_valid & jalr_x1 & x1_busy;

endmodule

// ==== source/ifu_minidec.sv ====
`timescale 1ns/1ps

module ifu_minidec (
   input  logic [ifu_pkg::INSTR_SIZE-1:0] instr,
   output ifu_pkg::minidec_t              dec
);
   import ifu_pkg::*;

   // rv32i major opcodes
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_AUIPC  = 7'b0010111,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011
   } opcode_e;

   opcode_e         opcode;
   logic [XLEN-1:0] imm_j;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_b;

   assign opcode = opcode_e'(instr[6:0]);

   // immediates for the three control transfer formats
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

   always_comb begin
      // register fields sit at fixed positions in every format
      dec.rs1idx  = instr[19:15];
      dec.rs2idx  = instr[24:20];
      dec.rs1en   = 1'b0;
      dec.rs2en   = 1'b0;
      dec.kind    = BJP_NONE;
      dec.bjp_imm = '0;
      case (opcode)
         OP_JAL: begin
            dec.kind    = BJP_JAL;
            dec.bjp_imm = imm_j;
         end
         OP_JALR: begin
            dec.rs1en   = 1'b1;
            dec.kind    = BJP_JALR;
            dec.bjp_imm = imm_i;
         end
         OP_BRANCH: begin
            dec.rs1en   = 1'b1;
            dec.rs2en   = 1'b1;
            dec.kind    = BJP_BXX;
            dec.bjp_imm = imm_b;
         end
         OP_LOAD, OP_IMM: begin
            dec.rs1en   = 1'b1;
         end
         OP_STORE, OP_REG: begin
            dec.rs1en   = 1'b1;
            dec.rs2en   = 1'b1;
         end
         // lui, auipc and anything unknown read no registers
         default: begin
            dec.kind    = BJP_NONE;
         end
      endcase
   end

endmodule

// ==== source/ifu_pkg.sv ====
package ifu_pkg;

   // datapath widths
   localparam int PC_SIZE     = 32;
   localparam int INSTR_SIZE  = 32;
   localparam int XLEN        = 32;
   localparam int RFIDX_WIDTH = 5;

   // itcm word address width, 64 words
   localparam int ITCM_AW     = 6;

   // control transfer class seen by the mini decoder
   typedef enum logic [1:0] {
      BJP_NONE = 2'd0,
      BJP_JAL  = 2'd1,
      BJP_JALR = 2'd2,
      BJP_BXX  = 2'd3
   } bjp_kind_e;

   // partial decode of the returned instruction
   typedef struct packed {
      logic                   rs1en;
      logic                   rs2en;
      logic [RFIDX_WIDTH-1:0] rs1idx;
      logic [RFIDX_WIDTH-1:0] rs2idx;
      bjp_kind_e              kind;
      // sign extended J, I or B immediate
      logic [XLEN-1:0]        bjp_imm;
   } minidec_t;

   // instruction handed to execute
   typedef struct packed {
      logic [INSTR_SIZE-1:0]  ir;
      logic [PC_SIZE-1:0]     pc;
      logic [RFIDX_WIDTH-1:0] rs1idx;
      logic [RFIDX_WIDTH-1:0] rs2idx;
      logic                   prdt_taken;
   } if_ex_t;

   // flush target, sum of both operands with the low two bits cleared
   typedef struct packed {
      logic [PC_SIZE-1:0]     add_op1;
      logic [PC_SIZE-1:0]     add_op2;
   } flush_t;

endpackage
